// ==== include/dcache_macros.svh ====
// -------------------------------------------------------------------------
// L1 data cache bank geometry
// -------------------------------------------------------------------------

`ifndef DCACHE_MACROS_SVH
`define DCACHE_MACROS_SVH

// Associativity and lines per way
`define DCACHE_WAYS        4
`define DCACHE_SETS        16

// Bytes per line, 128-bit data
`define DCACHE_LINE_BYTES  16

// Physical address width
`define DCACHE_PADDR_W     32

// Load ports into the bank
`define DCACHE_READ_PORTS  2

// Write queue entries, equal to the credits the producer starts with
`define DCACHE_WRQ_DEPTH   4

`endif

// ==== source/dcache_pkg.sv ====
// -------------------------------------------------------------------------
// L1 data cache types
// -------------------------------------------------------------------------

`include "dcache_macros.svh"

package dcache_pkg;

  localparam int DC_OFFSET_W = $clog2(`DCACHE_LINE_BYTES);
  localparam int DC_SET_W    = $clog2(`DCACHE_SETS);
  localparam int DC_WAY_W    = $clog2(`DCACHE_WAYS);
  localparam int DC_TAG_W    = `DCACHE_PADDR_W - DC_SET_W - DC_OFFSET_W;
  localparam int DC_DATA_W   = `DCACHE_LINE_BYTES * 8;

  // Address layout is tag | set | offset
  typedef logic [`DCACHE_PADDR_W-1:0]    paddr_t;
  typedef logic [DC_TAG_W-1:0]           dc_tag_t;
  typedef logic [DC_SET_W-1:0]           dc_set_t;
  typedef logic [DC_WAY_W-1:0]           dc_way_t;
  typedef logic [DC_DATA_W-1:0]          dc_data_t;
  typedef logic [`DCACHE_LINE_BYTES-1:0] dc_be_t;

  typedef enum logic [1:0] {
    INVALID   = 2'd0,
    SHARED    = 2'd1,
    EXCLUSIVE = 2'd2,
    MODIFIED  = 2'd3
  } mesi_t;

  typedef struct packed {
    logic   valid;
    logic   high_priority;
    paddr_t paddr;
  } dc_read_req_t;

  typedef struct packed {
    logic     hit;
    logic     miss;
    logic     conflict;
    dc_way_t  hit_way;
    dc_data_t data;
    mesi_t    mesi;
  } dc_read_resp_t;

  // tag_update set for a line fill, clear for a store
  typedef struct packed {
    logic     valid;
    logic     tag_update;
    paddr_t   paddr;
    dc_way_t  way;
    dc_be_t   be;
    dc_data_t data;
    mesi_t    mesi;
  } dc_wr_req_t;

  typedef struct packed {
    logic     s1_hit;
    logic     s1_miss;
    logic     s2_evicted_valid;
    paddr_t   s2_evicted_paddr;
    dc_data_t s2_evicted_data;
    mesi_t    s2_evicted_mesi;
  } dc_wr_resp_t;

  function automatic dc_tag_t dc_tag_of(input paddr_t paddr);
    return paddr[`DCACHE_PADDR_W-1 -: DC_TAG_W];
  endfunction

  function automatic dc_set_t dc_set_of(input paddr_t paddr);
    return paddr[DC_OFFSET_W +: DC_SET_W];
  endfunction

endpackage

// ==== source/dcache_tag_array.sv ====
// -------------------------------------------------------------------------
// Data cache tag array, one way
// -------------------------------------------------------------------------

`include "dcache_macros.svh"

module dcache_tag_array
  import dcache_pkg::*;
(
  input  logic    i_clk,
  input  logic    i_reset_n,
  input  logic    i_wr,
  input  dc_set_t i_addr,
  input  dc_tag_t i_tag,
  input  mesi_t   i_mesi,
  output dc_tag_t o_tag,
  output mesi_t   o_mesi,
  output logic    o_valid
);

  dc_tag_t                 r_tag_mem  [`DCACHE_SETS];
  mesi_t                   r_mesi_mem [`DCACHE_SETS];
  logic [`DCACHE_SETS-1:0] r_valid;

  // Read returns the old contents when the same set is written
  always_ff @(posedge i_clk) begin
    if (i_wr) begin
      r_tag_mem[i_addr]  <= i_tag;
      r_mesi_mem[i_addr] <= i_mesi;
    end
    o_tag  <= r_tag_mem[i_addr];
    o_mesi <= r_mesi_mem[i_addr];
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_valid <= '0;
      o_valid <= 1'b0;
    end else begin
      if (i_wr) begin
        r_valid[i_addr] <= 1'b1;
      end
      o_valid <= r_valid[i_addr];
    end
  end

endmodule

// ==== source/dcache_data_array.sv ====
// -------------------------------------------------------------------------
// Data cache line array, one way
// -------------------------------------------------------------------------

`include "dcache_macros.svh"

module dcache_data_array
  import dcache_pkg::*;
(
  input  logic     i_clk,
  input  logic     i_reset_n,
  input  logic     i_wr,
  input  dc_set_t  i_addr,
  input  dc_be_t   i_be,
  input  dc_data_t i_data,
  output dc_data_t o_data
);

  localparam int BYTES = `DCACHE_LINE_BYTES;

  dc_data_t r_mem [`DCACHE_SETS];

  // Byte-masked write, registered read of the old line
  always_ff @(posedge i_clk) begin
    if (i_wr) begin
      for (int b = 0; b < BYTES; b++) begin
        if (i_be[b]) begin
          r_mem[i_addr][b*8 +: 8] <= i_data[b*8 +: 8];
        end
      end
    end
    o_data <= r_mem[i_addr];
  end

  // Write controls come from the s1 stage of the bank and must be settled
  a_wr_known : assert property (
    @(posedge i_clk) disable iff (!i_reset_n)
    i_wr |-> !$isunknown({i_addr, i_be})
  ) else $error("data array write with unknown address or byte enables");

endmodule

// ==== source/dcache_wr_queue.sv ====
// -------------------------------------------------------------------------
// Data cache write queue with credit return
// -------------------------------------------------------------------------

`include "dcache_macros.svh"

module dcache_wr_queue
  import dcache_pkg::*;
(
  input  logic       i_clk,
  input  logic       i_reset_n,
  input  dc_wr_req_t i_req,
  output dc_wr_req_t o_issue,
  output logic       o_credit
);

  localparam int DEPTH = `DCACHE_WRQ_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  dc_wr_req_t       r_entry [DEPTH];
  logic [PTR_W-1:0] r_wr_ptr;
  logic [PTR_W-1:0] r_rd_ptr;
  logic [CNT_W-1:0] r_count;

  logic w_push;
  logic w_pop;
  logic w_empty;
  logic w_full;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign w_empty = (r_count == '0);
  assign w_full  = (r_count == CNT_W'(DEPTH));
  assign w_push  = i_req.valid;
  // Head leaves every cycle, the array never stalls a write
  assign w_pop   = !w_empty;

  // -------------------------------------------------------------------------
  // Pointers and occupancy
  // -------------------------------------------------------------------------
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_wr_ptr <= '0;
      r_rd_ptr <= '0;
      r_count  <= '0;
    end else begin
      if (w_push) begin
        r_wr_ptr <= next_ptr(r_wr_ptr);
      end
      if (w_pop) begin
        r_rd_ptr <= next_ptr(r_rd_ptr);
      end
      case ({w_push, w_pop})
        2'b10:   r_count <= r_count + 1'b1;
        2'b01:   r_count <= r_count - 1'b1;
        default: r_count <= r_count;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (w_push) begin
      r_entry[r_wr_ptr] <= i_req;
    end
  end

  always_comb begin
    o_issue       = r_entry[r_rd_ptr];
    o_issue.valid = w_pop;
  end

  // One credit back per entry handed to the array
  assign o_credit = w_pop;

  // Producer holds no credit when the queue is full
  a_no_push_full : assert property (
    @(posedge i_clk) disable iff (!i_reset_n)
    w_push |-> !w_full
  ) else $error("write queue push while full");

endmodule

// ==== source/dcache_bank_array.sv ====
// -------------------------------------------------------------------------
// Data cache bank tag and data arrays with read arbitration
// -------------------------------------------------------------------------

`include "dcache_macros.svh"

module dcache_bank_array
  import dcache_pkg::*;
(
  input  logic          i_clk,
  input  logic          i_reset_n,
  input  dc_wr_req_t    i_wr_req,
  output dc_wr_resp_t   o_wr_resp,
  input  dc_read_req_t  i_rd_req  [`DCACHE_READ_PORTS],
  output dc_read_resp_t o_rd_resp [`DCACHE_READ_PORTS]
);

  localparam int NP = `DCACHE_READ_PORTS;
  localparam int NW = `DCACHE_WAYS;

  // s0
  logic [NP-1:0] w_s0_rd_valid;
  logic [NP-1:0] w_s0_rd_prio;
  logic [NP-1:0] w_s0_rd_cand;
  logic [NP-1:0] w_s0_rd_sel;
  logic [NP-1:0] w_s0_same_set;
  logic [NP-1:0] w_s0_conflict;
  dc_set_t       w_s0_sel_set;
  dc_set_t       w_s0_tag_addr;
  dc_set_t       w_s0_data_addr;
  logic          w_s0_tag_wr;

  // s1
  logic          r_s1_wr_valid;
  logic          r_s1_wr_fill;
  dc_tag_t       r_s1_wr_tag;
  dc_set_t       r_s1_wr_set;
  dc_way_t       r_s1_wr_way;
  dc_be_t        r_s1_wr_be;
  dc_data_t      r_s1_wr_data;
  logic [NP-1:0] r_s1_rd_serve;
  logic [NP-1:0] r_s1_rd_conflict;
  dc_tag_t       r_s1_rd_tag [NP];
  logic          w_s1_wr_hit;
  logic          w_s1_data_wr;
  logic          w_s1_evict;
  dc_be_t        w_s1_data_be;

  // Way outputs, registered inside the arrays
  dc_tag_t       w_s1_tag      [NW];
  mesi_t         w_s1_mesi     [NW];
  logic [NW-1:0] w_s1_tag_valid;
  logic [NW-1:0] w_s1_live;
  dc_data_t      w_way_rdata   [NW];

  // s2
  logic          r_s2_evict_valid;
  dc_tag_t       r_s2_evict_tag;
  dc_set_t       r_s2_evict_set;
  mesi_t         r_s2_evict_mesi;
  dc_way_t       r_s2_way;

  // -------------------------------------------------------------------------
  // s0 arbitration and array addressing
  // -------------------------------------------------------------------------
  always_comb begin
    for (int p = 0; p < NP; p++) begin
      w_s0_rd_valid[p] = i_rd_req[p].valid;
      w_s0_rd_prio[p]  = i_rd_req[p].valid & i_rd_req[p].high_priority;
    end
    w_s0_rd_cand = (|w_s0_rd_prio) ? w_s0_rd_prio : w_s0_rd_valid;
    // Lowest set bit of the candidates
    w_s0_rd_sel  = w_s0_rd_cand & (~w_s0_rd_cand + 1'b1);
    w_s0_sel_set = '0;
    for (int p = 0; p < NP; p++) begin
      if (w_s0_rd_sel[p]) begin
        w_s0_sel_set = dc_set_of(i_rd_req[p].paddr);
      end
    end
    for (int p = 0; p < NP; p++) begin
      w_s0_same_set[p] = (dc_set_of(i_rd_req[p].paddr) == w_s0_sel_set);
      w_s0_conflict[p] = w_s0_rd_valid[p] &
                         (i_wr_req.valid | r_s1_wr_valid |
                          !(w_s0_rd_sel[p] | w_s0_same_set[p]));
    end
  end

  // Writes own the tag port, a data write in s1 owns the data port
  assign w_s0_tag_addr  = i_wr_req.valid ? dc_set_of(i_wr_req.paddr) : w_s0_sel_set;
  assign w_s0_data_addr = w_s1_data_wr ? r_s1_wr_set : w_s0_tag_addr;
  assign w_s0_tag_wr    = i_wr_req.valid & i_wr_req.tag_update;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_s1_wr_valid    <= 1'b0;
      r_s1_wr_fill     <= 1'b0;
      r_s1_rd_serve    <= '0;
      r_s1_rd_conflict <= '0;
      r_s2_evict_valid <= 1'b0;
    end else begin
      r_s1_wr_valid    <= i_wr_req.valid;
      r_s1_wr_fill     <= w_s0_tag_wr;
      r_s1_rd_serve    <= w_s0_rd_valid & ~w_s0_conflict;
      r_s1_rd_conflict <= w_s0_conflict;
      r_s2_evict_valid <= w_s1_evict;
    end
  end

  always_ff @(posedge i_clk) begin
    r_s1_wr_tag  <= dc_tag_of(i_wr_req.paddr);
    r_s1_wr_set  <= dc_set_of(i_wr_req.paddr);
    r_s1_wr_way  <= i_wr_req.way;
    r_s1_wr_be   <= i_wr_req.be;
    r_s1_wr_data <= i_wr_req.data;
    for (int p = 0; p < NP; p++) begin
      r_s1_rd_tag[p] <= dc_tag_of(i_rd_req[p].paddr);
    end
    r_s2_evict_tag  <= w_s1_tag[r_s1_wr_way];
    r_s2_evict_set  <= r_s1_wr_set;
    r_s2_evict_mesi <= w_s1_mesi[r_s1_wr_way];
    r_s2_way        <= r_s1_wr_way;
  end

  // -------------------------------------------------------------------------
  // s1 write hit, data write and eviction
  // -------------------------------------------------------------------------
  // A line counts only with its valid bit set and a state other than INVALID
  always_comb begin
    for (int w = 0; w < NW; w++) begin
      w_s1_live[w] = w_s1_tag_valid[w] & (w_s1_mesi[w] != INVALID);
    end
  end

  // Stores check only the way they name
  assign w_s1_wr_hit  = w_s1_live[r_s1_wr_way] & (w_s1_tag[r_s1_wr_way] == r_s1_wr_tag);
  assign w_s1_data_wr = r_s1_wr_valid & (r_s1_wr_fill | w_s1_wr_hit);
  assign w_s1_data_be = r_s1_wr_fill ? '1 : r_s1_wr_be;
  assign w_s1_evict   = r_s1_wr_valid & r_s1_wr_fill & w_s1_live[r_s1_wr_way] &
                        (w_s1_tag[r_s1_wr_way] != r_s1_wr_tag);

  // Old line comes out of the data array one cycle after the s1 fill write
  always_comb begin
    o_wr_resp.s1_hit           = r_s1_wr_valid & w_s1_wr_hit;
    o_wr_resp.s1_miss          = r_s1_wr_valid & !w_s1_wr_hit;
    o_wr_resp.s2_evicted_valid = r_s2_evict_valid;
    o_wr_resp.s2_evicted_paddr = {r_s2_evict_tag, r_s2_evict_set, {DC_OFFSET_W{1'b0}}};
    o_wr_resp.s2_evicted_data  = w_way_rdata[r_s2_way];
    o_wr_resp.s2_evicted_mesi  = r_s2_evict_mesi;
  end

  // -------------------------------------------------------------------------
  // s1 read responses
  // -------------------------------------------------------------------------
  for (genvar p = 0; p < NP; p++) begin : g_port
    logic [NW-1:0] w_hit_vec;
    dc_way_t       w_hit_way;
    dc_data_t      w_hit_data;
    mesi_t         w_hit_mesi;

    always_comb begin
      w_hit_way  = '0;
      w_hit_data = '0;
      w_hit_mesi = INVALID;
      for (int w = 0; w < NW; w++) begin
        w_hit_vec[w] = w_s1_live[w] & (w_s1_tag[w] == r_s1_rd_tag[p]);
        if (w_hit_vec[w]) begin
          w_hit_way  = dc_way_t'(w);
          w_hit_data = w_way_rdata[w];
          w_hit_mesi = w_s1_mesi[w];
        end
      end
    end

    always_comb begin
      o_rd_resp[p].hit      = r_s1_rd_serve[p] & (|w_hit_vec);
      o_rd_resp[p].miss     = r_s1_rd_serve[p] & ~(|w_hit_vec);
      o_rd_resp[p].conflict = r_s1_rd_conflict[p];
      o_rd_resp[p].hit_way  = w_hit_way;
      o_rd_resp[p].data     = w_hit_data;
      o_rd_resp[p].mesi     = w_hit_mesi;
    end

    // Fills must never leave one tag live in two ways of a set
    a_hit_onehot : assert property (
      @(posedge i_clk) disable iff (!i_reset_n)
      r_s1_rd_serve[p] |-> $onehot0(w_hit_vec)
    ) else $error("read port %0d hits in more than one way", p);
  end

  // -------------------------------------------------------------------------
  // Ways
  // -------------------------------------------------------------------------
  for (genvar w = 0; w < NW; w++) begin : g_way
    dcache_tag_array u_tag (
      .i_clk     (i_clk),
      .i_reset_n (i_reset_n),
      .i_wr      (w_s0_tag_wr & (i_wr_req.way == dc_way_t'(w))),
      .i_addr    (w_s0_tag_addr),
      .i_tag     (dc_tag_of(i_wr_req.paddr)),
      .i_mesi    (i_wr_req.mesi),
      .o_tag     (w_s1_tag[w]),
      .o_mesi    (w_s1_mesi[w]),
      .o_valid   (w_s1_tag_valid[w])
    );

    dcache_data_array u_data (
      .i_clk     (i_clk),
      .i_reset_n (i_reset_n),
      .i_wr      (w_s1_data_wr & (r_s1_wr_way == dc_way_t'(w))),
      .i_addr    (w_s0_data_addr),
      .i_be      (w_s1_data_be),
      .i_data    (r_s1_wr_data),
      .o_data    (w_way_rdata[w])
    );
  end

endmodule

// ==== source/dcache_bank.sv ====
// -------------------------------------------------------------------------
// L1 data cache bank
// -------------------------------------------------------------------------

`include "dcache_macros.svh"

module dcache_bank
  import dcache_pkg::*;
(
  input  logic          i_clk,
  input  logic          i_reset_n,
  input  dc_wr_req_t    i_wr_req,
  output logic          o_wr_credit,
  output dc_wr_resp_t   o_wr_resp,
  input  dc_read_req_t  i_rd_req  [`DCACHE_READ_PORTS],
  output dc_read_resp_t o_rd_resp [`DCACHE_READ_PORTS]
);

  // Write issued from the queue head, one per cycle
  dc_wr_req_t w_wr_issue;

  // Fills and stores wait here under credit control
  dcache_wr_queue u_wr_queue (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_req     (i_wr_req),
    .o_issue   (w_wr_issue),
    .o_credit  (o_wr_credit)
  );

  // Reads enter directly, a busy bank answers with a conflict
  dcache_bank_array u_array (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_wr_req  (w_wr_issue),
    .o_wr_resp (o_wr_resp),
    .i_rd_req  (i_rd_req),
    .o_rd_resp (o_rd_resp)
  );

endmodule

// ==== tests/tb_dcache_bank.sv ====
// -------------------------------------------------------------------------
// Data cache bank testbench
// -------------------------------------------------------------------------

`include "dcache_macros.svh"

module tb_dcache_bank
  import dcache_pkg::*;
();

  localparam int CLK_PERIOD   = 4;
  localparam int RESET_CYCLES = 10;
  localparam int EMPTY_READS  = 8;
  localparam int NUM_OPS      = 300;
  localparam int NP           = `DCACHE_READ_PORTS;
  localparam int NW           = `DCACHE_WAYS;
  localparam int DEPTH        = `DCACHE_WRQ_DEPTH;
  localparam int TIMEOUT_CYCLES = (NUM_OPS + EMPTY_READS) * 20 + RESET_CYCLES;

  logic          clk;
  logic          reset_n;
  dc_wr_req_t    wr_req;
  logic          wr_credit;
  dc_wr_resp_t   wr_resp;
  dc_read_req_t  rd_req  [NP];
  dc_read_resp_t rd_resp [NP];
  dc_read_req_t  rd_stim [NP];

  // Reference image of the cache contents
  logic          m_valid [`DCACHE_SETS][NW];
  dc_tag_t       m_tag   [`DCACHE_SETS][NW];
  mesi_t         m_mesi  [`DCACHE_SETS][NW];
  dc_data_t      m_data  [`DCACHE_SETS][NW];

  logic [15:0]   lfsr_state;
  int            errors;
  int            credits;
  int            credits_back;

  dcache_bank uut (
    .i_clk       (clk),
    .i_reset_n   (reset_n),
    .i_wr_req    (wr_req),
    .o_wr_credit (wr_credit),
    .o_wr_resp   (wr_resp),
    .i_rd_req    (rd_req),
    .o_rd_resp   (rd_resp)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // Producer side credit counter
  always @(negedge clk) begin
    if (wr_credit === 1'b1) begin
      credits++;
      credits_back++;
    end
  end

  initial begin
    #(TIMEOUT_CYCLES * CLK_PERIOD);
    $display("Simulation timed out after %0d cycles", TIMEOUT_CYCLES);
    $display("Test failures found");
    $finish;
  end

  // -------------------------------------------------------------------------
  // Random source and reference model
  // -------------------------------------------------------------------------
  // 16-bit Fibonacci LFSR, taps 16 14 13 11
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
      lfsr_state = {lfsr_state[14:0], fb};
      v = {v[30:0], fb};
    end
    return v;
  endfunction

  // Four tags over four sets keep hits and evictions frequent
  function automatic paddr_t random_paddr();
    paddr_t a;
    a[31:8] = 24'h5A0000 | 24'(rand_bits(2));
    a[7:4]  = 4'(rand_bits(2));
    a[3:0]  = 4'(rand_bits(4));
    return a;
  endfunction

  function automatic logic line_live(input dc_set_t s, input int w);
    return m_valid[s][w] && (m_mesi[s][w] != INVALID);
  endfunction

  function automatic int model_way(input paddr_t a);
    int way;
    way = -1;
    for (int w = 0; w < NW; w++) begin
      if (line_live(a[7:4], w) && (m_tag[a[7:4]][w] == a[31:8])) begin
        way = w;
      end
    end
    return way;
  endfunction

  function automatic dc_wr_req_t random_write(input logic fill, input logic aim_hit);
    dc_wr_req_t r;
    int         w;
    r            = '0;
    r.valid      = 1'b1;
    r.tag_update = fill;
    r.paddr      = random_paddr();
    r.way        = dc_way_t'(rand_bits(2));
    r.be         = dc_be_t'(rand_bits(16));
    for (int i = 0; i < 4; i++) begin
      r.data[i*32 +: 32] = rand_bits(32);
    end
    r.mesi = mesi_t'(rand_bits(2));
    // A live tag is never placed in a second way of its set
    w = model_way(r.paddr);
    if ((fill || aim_hit) && (w >= 0)) begin
      r.way = dc_way_t'(w);
    end
    return r;
  endfunction

  task automatic check_value(input logic [127:0] got, input logic [127:0] exp,
                             input string what);
    if (got !== exp) begin
      $display("Error at time %0t: %s, got %0h expected %0h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic apply_write(input dc_wr_req_t r, output logic exp_hit,
                             output logic exp_evict, output paddr_t ev_paddr,
                             output dc_data_t ev_data, output mesi_t ev_mesi);
    dc_set_t s;
    dc_tag_t t;
    int      w;
    s         = r.paddr[7:4];
    t         = r.paddr[31:8];
    w         = r.way;
    exp_hit   = line_live(s, w) && (m_tag[s][w] == t);
    exp_evict = r.tag_update && line_live(s, w) && (m_tag[s][w] != t);
    ev_paddr  = {m_tag[s][w], s, 4'h0};
    ev_data   = m_data[s][w];
    ev_mesi   = m_mesi[s][w];
    if (r.tag_update) begin
      m_valid[s][w] = 1'b1;
      m_tag[s][w]   = t;
      m_mesi[s][w]  = r.mesi;
      m_data[s][w]  = r.data;
    end else if (exp_hit) begin
      for (int b = 0; b < `DCACHE_LINE_BYTES; b++) begin
        if (r.be[b]) begin
          m_data[s][w][b*8 +: 8] = r.data[b*8 +: 8];
        end
      end
    end
  endtask

  // -------------------------------------------------------------------------
  // Read port stimulus and checks
  // -------------------------------------------------------------------------
  task automatic random_reads();
    for (int p = 0; p < NP; p++) begin
      rd_stim[p].valid         = (p == 0) || (rand_bits(2) != 0);
      rd_stim[p].high_priority = rand_bits(1);
      rd_stim[p].paddr         = random_paddr();
    end
  endtask

  task automatic drive_reads(input logic on);
    for (int p = 0; p < NP; p++) begin
      rd_req[p] = on ? rd_stim[p] : '0;
    end
  endtask

  task automatic check_port(input int p, input logic served, input logic confl);
    int      w;
    dc_set_t s;
    w = model_way(rd_stim[p].paddr);
    s = rd_stim[p].paddr[7:4];
    check_value(rd_resp[p].conflict, confl, $sformatf("port %0d conflict", p));
    check_value(rd_resp[p].hit, served && (w >= 0), $sformatf("port %0d hit", p));
    check_value(rd_resp[p].miss, served && (w < 0), $sformatf("port %0d miss", p));
    if (served && (w >= 0)) begin
      check_value(rd_resp[p].hit_way, w, $sformatf("port %0d hit way", p));
      check_value(rd_resp[p].data, m_data[s][w], $sformatf("port %0d data", p));
      check_value(rd_resp[p].mesi, m_mesi[s][w], $sformatf("port %0d state", p));
    end
  endtask

  task automatic check_conflicts();
    for (int p = 0; p < NP; p++) begin
      check_port(p, 1'b0, rd_stim[p].valid);
    end
  endtask

  // Priority requests first, then the lowest port, plus every port in its set
  task automatic read_ports();
    logic [NP-1:0] served;
    int            sel;
    dc_set_t       sel_set;
    sel     = -1;
    sel_set = '0;
    for (int p = 0; p < NP; p++) begin
      if (sel < 0 && rd_stim[p].valid && rd_stim[p].high_priority) sel = p;
    end
    for (int p = 0; p < NP; p++) begin
      if (sel < 0 && rd_stim[p].valid) sel = p;
    end
    if (sel >= 0) begin
      sel_set = rd_stim[sel].paddr[7:4];
    end
    for (int p = 0; p < NP; p++) begin
      served[p] = rd_stim[p].valid && (sel >= 0) && (rd_stim[p].paddr[7:4] == sel_set);
    end
    @(posedge clk);
    #1;
    drive_reads(1'b1);
    @(posedge clk);
    #1;
    drive_reads(1'b0);
    @(negedge clk);
    for (int p = 0; p < NP; p++) begin
      check_port(p, served[p], rd_stim[p].valid && !served[p]);
    end
  endtask

  task automatic read_same(input paddr_t a);
    for (int p = 0; p < NP; p++) begin
      rd_stim[p].valid         = 1'b1;
      rd_stim[p].high_priority = rand_bits(1);
      rd_stim[p].paddr         = a;
    end
    read_ports();
  endtask

  // -------------------------------------------------------------------------
  // Write path
  // -------------------------------------------------------------------------
  task automatic write_single(input dc_wr_req_t r, input logic overlap);
    logic     exp_hit;
    logic     exp_evict;
    paddr_t   ev_paddr;
    dc_data_t ev_data;
    mesi_t    ev_mesi;
    apply_write(r, exp_hit, exp_evict, ev_paddr, ev_data, ev_mesi);
    if (overlap) random_reads();
    @(posedge clk);
    #1;
    wr_req = r;
    credits--;
    @(posedge clk);
    #1;
    wr_req = '0;
    // Reads overlap the issue cycle and then the s1 cycle
    if (overlap) drive_reads(1'b1);
    @(negedge clk);
    while (wr_credit !== 1'b1) @(negedge clk);
    @(negedge clk);
    check_value(wr_resp.s1_hit, exp_hit, "write s1_hit");
    check_value(wr_resp.s1_miss, !exp_hit, "write s1_miss");
    if (overlap) check_conflicts();
    @(posedge clk);
    #1;
    drive_reads(1'b0);
    @(negedge clk);
    check_value(wr_resp.s2_evicted_valid, exp_evict, "eviction valid");
    if (exp_evict) begin
      check_value(wr_resp.s2_evicted_paddr, ev_paddr, "evicted address");
      check_value(wr_resp.s2_evicted_data, ev_data, "evicted data");
      check_value(wr_resp.s2_evicted_mesi, ev_mesi, "evicted state");
    end
    if (overlap) check_conflicts();
  endtask

  task automatic write_burst(input int n);
    dc_wr_req_t r;
    int         ret0;
    int         waited;
    logic       h;
    logic       e;
    paddr_t     a;
    dc_data_t   d;
    mesi_t      m;
    ret0 = credits_back;
    for (int i = 0; i < n; i++) begin
      r = random_write(rand_bits(1), rand_bits(1));
      apply_write(r, h, e, a, d, m);
      @(posedge clk);
      #1;
      if (credits <= 0) begin
        $display("Write burst ran out of credits at time %0t", $time);
        errors++;
      end
      wr_req = r;
      credits--;
    end
    @(posedge clk);
    #1;
    wr_req = '0;
    // Queue drains one entry per cycle, so a few cycles bound the return
    waited = 0;
    while ((credits_back - ret0 < n) && (waited < 2 * DEPTH)) begin
      @(posedge clk);
      waited++;
    end
    @(posedge clk);
    check_value(credits_back - ret0, n, "credits returned by burst");
    check_value(credits, DEPTH, "credits held after burst");
  endtask

  // -------------------------------------------------------------------------
  // Test sequence
  // -------------------------------------------------------------------------
  initial begin
    logic [2:0] kind;
    dc_wr_req_t wr;
    clk          = 1'b0;
    reset_n      = 1'b0;
    wr_req       = '0;
    errors       = 0;
    credits      = DEPTH;
    credits_back = 0;
    lfsr_state   = 16'd70;
    for (int p = 0; p < NP; p++) begin
      rd_req[p]  = '0;
      rd_stim[p] = '0;
    end
    for (int s = 0; s < `DCACHE_SETS; s++) begin
      for (int w = 0; w < NW; w++) begin
        m_valid[s][w] = 1'b0;
        m_tag[s][w]   = '0;
        m_mesi[s][w]  = INVALID;
        m_data[s][w]  = '0;
      end
    end
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    reset_n = 1'b1;

    // Empty cache, every served read misses
    for (int i = 0; i < EMPTY_READS; i++) begin
      random_reads();
      read_ports();
    end

    for (int op = 0; op < NUM_OPS; op++) begin
      kind = rand_bits(3);
      case (kind)
        3'd0: begin
          wr = random_write(1'b1, 1'b1);
          write_single(wr, 1'b0);
          read_same(wr.paddr);
        end
        3'd1: write_single(random_write(1'b1, 1'b1), 1'b0);
        3'd2: begin
          wr = random_write(1'b0, 1'b1);
          write_single(wr, 1'b0);
          read_same(wr.paddr);
        end
        3'd3: write_single(random_write(1'b0, 1'b0), 1'b0);
        3'd4, 3'd5: begin
          random_reads();
          read_ports();
        end
        3'd6: write_burst(int'(rand_bits(2)) + 1);
        default: write_single(random_write(rand_bits(1), 1'b1), 1'b1);
      endcase
    end

    @(posedge clk);
    check_value(credits, DEPTH, "credits held at end of run");
    $display("Run finished with %0d errors", errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// ==== vlog.f ====
+incdir+include
source/dcache_pkg.sv
source/dcache_tag_array.sv
source/dcache_data_array.sv
source/dcache_wr_queue.sv
source/dcache_bank_array.sv
source/dcache_bank.sv
tests/tb_dcache_bank.sv

// ==== Bender.yml ====
package:
  name: dcache_bank

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - source/dcache_pkg.sv
      - source/dcache_tag_array.sv
      - source/dcache_data_array.sv
      - source/dcache_wr_queue.sv
      - source/dcache_bank_array.sv
      - source/dcache_bank.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/tb_dcache_bank.sv
